// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_VECTOR = 32'h0000_0000;
    localparam word_t INSTR_LEN = 32'd4;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011
    } opcode_t;

    // funct3 of OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    // funct3 of BRANCH
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // one-hot branch condition, bit positions below
    typedef logic [5:0] branch_mask_t;
    localparam int BR_EQ = 0;
    localparam int BR_NE = 1;
    localparam int BR_LT = 2;
    localparam int BR_GE = 3;
    localparam int BR_LTU = 4;
    localparam int BR_GEU = 5;

    typedef enum logic [2:0] {
        ST_RESET, ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_BRANCH, ST_WRITEBACK
    } state_t;

endpackage

// File: logic/mem_req_if.sv
interface mem_req_if;

    logic req;
    logic we;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t wdata;
    cpu_pkg::word_t rdata;
    logic done;

    // sequencer side, one request in flight at most
    modport control (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport bus (
        input  req, we, addr, wdata,
        output rdata, done
    );

endinterface

// File: logic/alu.sv
module alu (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t a,
    input  cpu_pkg::word_t b,
    output cpu_pkg::word_t result,
    output logic lt,
    output logic ltu,
    output logic eq
);
    import cpu_pkg::*;

    word_t result_d;
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result_d = a + b;
            ALU_SUB:  result_d = a - b;
            ALU_SLL:  result_d = a << shamt;
            ALU_SLT:  result_d = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result_d = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result_d = a ^ b;
            ALU_SRL:  result_d = a >> shamt;
            ALU_SRA:  result_d = $signed(a) >>> shamt;
            ALU_OR:   result_d = a | b;
            ALU_AND:  result_d = a & b;
            default:  result_d = a + b;
        endcase
    end

    // result and flags hold until the next enable
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            lt <= 1'b0;
            ltu <= 1'b0;
            eq <= 1'b0;
        end else if (en) begin
            result <= result_d;
            lt <= $signed(a) < $signed(b);
            ltu <= a < b;
            eq <= a == b;
        end
    end

endmodule

// File: logic/decoder.sv
module decoder (
    input  logic clk,
    input  logic en,
    input  cpu_pkg::word_t instr,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::opcode_t opcode,
    output logic [2:0] funct3,
    output logic funct7_5,
    output cpu_pkg::word_t imm,
    output cpu_pkg::branch_mask_t branch_mask
);
    import cpu_pkg::*;

    opcode_t op_in;
    word_t imm_in;
    branch_mask_t mask_in;

    assign op_in = opcode_t'(instr[6:2]);

    // immediate format follows the opcode
    always_comb begin
        case (op_in)
            OPC_STORE:
                imm_in = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH:
                imm_in = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm_in = {instr[31:12], 12'b0};
            OPC_JAL:
                imm_in = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm_in = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        mask_in = '0;
        case (branch_f3_t'(instr[14:12]))
            F3_BEQ:  mask_in[BR_EQ] = 1'b1;
            F3_BNE:  mask_in[BR_NE] = 1'b1;
            F3_BLT:  mask_in[BR_LT] = 1'b1;
            F3_BGE:  mask_in[BR_GE] = 1'b1;
            F3_BLTU: mask_in[BR_LTU] = 1'b1;
            F3_BGEU: mask_in[BR_GEU] = 1'b1;
            // 010 and 011 never branch
            default: mask_in = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            rd <= instr[11:7];
            opcode <= op_in;
            funct3 <= instr[14:12];
            funct7_5 <= instr[30];
            imm <= imm_in;
            branch_mask <= mask_in;
        end
    end

endmodule

// File: logic/registers.sv
module registers (
    input  logic clk,
    input  logic we,
    input  cpu_pkg::reg_addr_t rd,
    input  cpu_pkg::word_t wdata,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::word_t val1,
    output cpu_pkg::word_t val2
);
    import cpu_pkg::*;

    word_t regs [0:2**REG_ADDR_W-1];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // entry 0 is left untouched, reads of x0 are forced to zero
    always_comb begin
        if (rs1 == '0) begin
            val1 = '0;
        end else begin
            val1 = regs[rs1];
        end
        if (rs2 == '0) begin
            val2 = '0;
        end else begin
            val2 = regs[rs2];
        end
    end

endmodule

// File: logic/wb_master.sv
module wb_master (
    input  logic clk,
    input  logic reset,
    mem_req_if.bus mem,
    input  logic wb_ack,
    input  cpu_pkg::word_t wb_dat_rd,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_dat_wr,
    output logic [cpu_pkg::XLEN/8-1:0] wb_sel,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we
);
    import cpu_pkg::*;

    // word transfers only
    assign wb_sel = {(XLEN/8){1'b1}};

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            if (wb_cyc) begin
                // slave may stall as long as it likes
                if (wb_ack) begin
                    wb_cyc <= 1'b0;
                    wb_stb <= 1'b0;
                    wb_we <= 1'b0;
                    mem.done <= 1'b1;
                end
            end else if (mem.req) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we <= mem.we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem.req && !wb_cyc) begin
            wb_adr <= mem.addr;
            wb_dat_wr <= mem.wdata;
        end
        if (wb_cyc && wb_ack && !wb_we) begin
            mem.rdata <= wb_dat_rd;
        end
    end

endmodule

// File: logic/control.sv
module control (
    input  logic clk,
    input  logic reset,
    mem_req_if.control mem,
    input  cpu_pkg::opcode_t dec_opcode,
    input  logic [2:0] dec_funct3,
    input  logic dec_funct7_5,
    input  cpu_pkg::word_t dec_imm,
    input  cpu_pkg::branch_mask_t dec_branch_mask,
    output logic dec_en,
    input  cpu_pkg::word_t reg_val1,
    input  cpu_pkg::word_t reg_val2,
    output logic reg_we,
    output cpu_pkg::word_t reg_wdata,
    output logic alu_en,
    output cpu_pkg::alu_op_t alu_op,
    output cpu_pkg::word_t alu_a,
    output cpu_pkg::word_t alu_b,
    input  cpu_pkg::word_t alu_result,
    input  logic alu_lt,
    input  logic alu_ltu,
    input  logic alu_eq
);
    import cpu_pkg::*;

    state_t state;
    word_t pc;
    word_t pc_next;
    word_t fetch_pc;
    logic next_from_alu;
    logic issued;
    logic is_jump;
    logic taken;
    alu_op_t funct_op;
    branch_mask_t flags;

    assign is_jump = (dec_opcode == OPC_JAL) || (dec_opcode == OPC_JALR);
    // jump and taken branch targets sit on the ALU output
    assign fetch_pc = next_from_alu ? (alu_result & ~word_t'(1)) : pc_next;

    always_comb begin
        flags[BR_EQ] = alu_eq;
        flags[BR_NE] = !alu_eq;
        flags[BR_LT] = alu_lt;
        flags[BR_GE] = !alu_lt;
        flags[BR_LTU] = alu_ltu;
        flags[BR_GEU] = !alu_ltu;
    end
    assign taken = |(dec_branch_mask & flags);

    always_comb begin
        case (funct3_t'(dec_funct3))
            F3_ADD_SUB: funct_op = (dec_opcode == OPC_OP && dec_funct7_5) ? ALU_SUB : ALU_ADD;
            F3_SLL:     funct_op = ALU_SLL;
            F3_SLT:     funct_op = ALU_SLT;
            F3_SLTU:    funct_op = ALU_SLTU;
            F3_XOR:     funct_op = ALU_XOR;
            F3_SRL_SRA: funct_op = dec_funct7_5 ? ALU_SRA : ALU_SRL;
            F3_OR:      funct_op = ALU_OR;
            default:    funct_op = ALU_AND;
        endcase
    end

    // operand select per state
    always_comb begin
        dec_en = (state == ST_DECODE);
        alu_en = 1'b0;
        alu_op = ALU_ADD;
        alu_a = reg_val1;
        alu_b = reg_val2;
        case (state)
            ST_DECODE: begin
                // idle ALU computes the fall-through PC
                alu_en = 1'b1;
                alu_a = pc;
                alu_b = INSTR_LEN;
            end
            ST_EXEC: begin
                // jumps keep PC+4 on the ALU output for the link write
                alu_en = !is_jump;
                case (dec_opcode)
                    OPC_OP: alu_op = funct_op;
                    OPC_OP_IMM: begin
                        alu_op = funct_op;
                        alu_b = dec_imm;
                    end
                    OPC_AUIPC: begin
                        alu_a = pc;
                        alu_b = dec_imm;
                    end
                    OPC_LOAD, OPC_STORE: alu_b = dec_imm;
                    default: alu_op = ALU_ADD;
                endcase
            end
            ST_BRANCH: begin
                alu_en = 1'b1;
                alu_a = pc;
                alu_b = dec_imm;
            end
            ST_WRITEBACK: begin
                alu_en = is_jump;
                alu_a = (dec_opcode == OPC_JAL) ? pc : reg_val1;
                alu_b = dec_imm;
            end
            default: alu_en = 1'b0;
        endcase
    end

    assign reg_we = (state == ST_WRITEBACK);
    always_comb begin
        case (dec_opcode)
            OPC_LOAD: reg_wdata = mem.rdata;
            OPC_LUI:  reg_wdata = dec_imm;
            default:  reg_wdata = alu_result;
        endcase
    end

    assign mem.we = (state == ST_MEM) && (dec_opcode == OPC_STORE);
    assign mem.addr = (state == ST_FETCH) ? fetch_pc : alu_result;
    assign mem.wdata = reg_val2;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
            pc <= RESET_VECTOR;
            pc_next <= RESET_VECTOR;
            next_from_alu <= 1'b0;
            issued <= 1'b0;
            mem.req <= 1'b0;
        end else begin
            mem.req <= 1'b0;
            case (state)
                ST_RESET: state <= ST_FETCH;
                ST_FETCH: begin
                    if (!issued) begin
                        mem.req <= 1'b1;
                        issued <= 1'b1;
                        pc <= fetch_pc;
                    end else if (mem.done) begin
                        issued <= 1'b0;
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: state <= ST_EXEC;
                ST_EXEC: begin
                    pc_next <= alu_result;
                    next_from_alu <= 1'b0;
                    case (dec_opcode)
                        OPC_OP, OPC_OP_IMM, OPC_AUIPC, OPC_LUI, OPC_JAL, OPC_JALR:
                            state <= ST_WRITEBACK;
                        OPC_LOAD, OPC_STORE: state <= ST_MEM;
                        OPC_BRANCH: state <= ST_BRANCH;
                        // fence and unknown opcodes fall through
                        default: state <= ST_FETCH;
                    endcase
                end
                ST_MEM: begin
                    if (!issued) begin
                        mem.req <= 1'b1;
                        issued <= 1'b1;
                    end else if (mem.done) begin
                        issued <= 1'b0;
                        state <= (dec_opcode == OPC_LOAD) ? ST_WRITEBACK : ST_FETCH;
                    end
                end
                ST_BRANCH: begin
                    next_from_alu <= taken;
                    state <= ST_FETCH;
                end
                ST_WRITEBACK: begin
                    next_from_alu <= is_jump;
                    state <= ST_FETCH;
                end
                default: state <= ST_RESET;
            endcase
        end
    end

endmodule

// File: logic/cpu.sv
module cpu (
    input  logic clk,
    input  logic reset,
    input  logic wb_ack,
    input  cpu_pkg::word_t wb_dat_rd,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_dat_wr,
    output logic [3:0] wb_sel,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we
);
    import cpu_pkg::*;

    mem_req_if mem_bus ();

    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    opcode_t dec_opcode;
    logic [2:0] dec_funct3;
    logic dec_funct7_5;
    word_t dec_imm;
    branch_mask_t dec_branch_mask;
    logic dec_en;
    word_t reg_val1;
    word_t reg_val2;
    word_t reg_wdata;
    logic reg_we;
    logic alu_en;
    alu_op_t alu_op;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic alu_lt;
    logic alu_ltu;
    logic alu_eq;

    control i_control (
        .clk, .reset, .mem(mem_bus.control),
        .dec_opcode, .dec_funct3, .dec_funct7_5, .dec_imm, .dec_branch_mask, .dec_en,
        .reg_val1, .reg_val2, .reg_we, .reg_wdata,
        .alu_en, .alu_op, .alu_a, .alu_b, .alu_result, .alu_lt, .alu_ltu, .alu_eq
    );

    // instruction word comes straight from the bus read latch
    decoder i_decoder (
        .clk, .en(dec_en), .instr(mem_bus.rdata),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .opcode(dec_opcode),
        .funct3(dec_funct3), .funct7_5(dec_funct7_5), .imm(dec_imm),
        .branch_mask(dec_branch_mask)
    );

    registers i_registers (
        .clk, .we(reg_we), .rd(dec_rd), .wdata(reg_wdata),
        .rs1(dec_rs1), .rs2(dec_rs2), .val1(reg_val1), .val2(reg_val2)
    );

    alu i_alu (
        .clk, .reset, .en(alu_en), .op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .lt(alu_lt), .ltu(alu_ltu), .eq(alu_eq)
    );

    wb_master i_wb_master (
        .clk, .reset, .mem(mem_bus.bus),
        .wb_ack, .wb_dat_rd, .wb_adr, .wb_dat_wr, .wb_sel, .wb_cyc, .wb_stb, .wb_we
    );

endmodule

// File: dv/cpu_asserts.sv
module cpu_asserts (
    input logic clk,
    input logic reset,
    input logic wb_ack,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input cpu_pkg::word_t wb_adr,
    input cpu_pkg::word_t wb_dat_wr,
    input logic [3:0] wb_sel
);
    timeunit 1ns;
    timeprecision 1ns;

    logic bus_used;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_used <= 1'b0;
        end else if (wb_cyc) begin
            bus_used <= 1'b1;
        end
    end

    // bus idle during reset and the cycle after
    assert property (@(posedge clk) reset |=> !wb_cyc && !wb_stb)
        else $error("bus active after a reset cycle");
    assert property (@(posedge clk) !reset && $past(reset) |=> !wb_cyc && !wb_stb)
        else $error("bus active right after reset");

    // first cycle out of reset fetches from the reset vector
    assert property (@(posedge clk) disable iff (reset)
        wb_cyc && !bus_used |-> !wb_we && wb_adr == '0)
        else $error("first bus cycle is not a read of address zero");

    assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("stb high without cyc");
    assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_sel == 4'hf)
        else $error("byte select not all ones");

    // master holds the request while the slave stalls
    assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_wr) && $stable(wb_we))
        else $error("bus request changed before ack");
    assert property (@(posedge clk) disable iff (reset)
        wb_cyc && wb_ack |=> !wb_cyc && !wb_stb)
        else $error("cycle not closed after ack");

endmodule

bind cpu cpu_asserts i_cpu_asserts (
    .clk(clk), .reset(reset), .wb_ack(wb_ack), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_wr(wb_dat_wr), .wb_sel(wb_sel)
);

// File: dv/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ns;
    import cpu_pkg::*;

    // major opcodes, full 7-bit form
    localparam int OPC_I = 7'h13;
    localparam int OPC_L = 7'h03;
    localparam int OPC_JR = 7'h67;
    localparam int OPC_U = 7'h37;
    localparam int OPC_AU = 7'h17;
    localparam word_t END_ADDR = 32'h0000_03fc;
    // about 80 executed instructions, 5 states of up to 5 cycles, doubled
    localparam int TIMEOUT_CYCLES = 80 * 5 * 5 * 2;

    logic clk;
    logic reset;
    logic wb_ack;
    word_t wb_dat_rd;
    word_t wb_adr;
    word_t wb_dat_wr;
    logic [3:0] wb_sel;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;

    word_t mem [0:255];
    word_t exp_addr [$];
    word_t exp_data [$];
    int exp_idx;
    int slot;
    word_t pc;
    word_t last_pc;
    logic [31:0] lfsr;
    logic test_done;

    cpu i_cpu (
        .clk, .reset, .wb_ack, .wb_dat_rd, .wb_adr, .wb_dat_wr,
        .wb_sel, .wb_cyc, .wb_stb, .wb_we
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    // instruction encoders
    function automatic word_t r_op(input int f7, input int f3, input int rd,
                                   input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t i_op(input int opc, input int f3, input int rd,
                                   input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t s_op(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t b_op(input int f3, input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t u_op(input int opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t j_op(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // the data word at 0x100 is jumped over
    task automatic put(input word_t instr);
        if (pc == 32'h0000_00fc) begin
            mem[pc[9:2]] = j_op(0, 8);
            pc = pc + 8;
        end
        mem[pc[9:2]] = instr;
        last_pc = pc;
        pc = pc + 4;
    endtask

    task automatic store_check(input int rs2, input word_t value);
        put(s_op(rs2, 10, slot));
        exp_addr.push_back(32'h200 + slot);
        exp_data.push_back(value);
        slot = slot + 4;
    endtask

    task automatic alu_check(input word_t instr, input word_t value);
        put(instr);
        store_check(3, value);
    endtask

    task automatic load_program();
        word_t base;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'ha5a5_0000 ^ (i << 2);
        end
        mem[64] = 32'hcafe_f00d;
        pc = '0;
        slot = 0;
        // x1 = 0x12345678, x2 = -3, x10 = result base
        put(u_op(OPC_U, 1, 32'h12345));
        put(i_op(OPC_I, 0, 1, 1, 32'h678));
        put(i_op(OPC_I, 0, 2, 0, -3));
        put(i_op(OPC_I, 0, 10, 0, 32'h200));
        store_check(1, 32'h1234_5678);
        // count down from 5, sum in x7
        put(i_op(OPC_I, 0, 6, 0, 5));
        put(i_op(OPC_I, 0, 7, 0, 0));
        put(r_op(0, 0, 7, 7, 6));
        put(i_op(OPC_I, 0, 6, 6, -1));
        put(b_op(1, 6, 0, -8));
        store_check(7, 32'd15);
        // taken beq, blt, bgeu each skip a stray store to 0x3f0
        put(b_op(0, 0, 0, 8));
        put(s_op(2, 10, 32'h1f0));
        put(b_op(4, 2, 1, 8));
        put(s_op(2, 10, 32'h1f0));
        put(b_op(7, 2, 1, 8));
        put(s_op(2, 10, 32'h1f0));
        put(b_op(0, 1, 2, 8));
        store_check(2, 32'hffff_fffd);
        put(j_op(8, 8));
        base = last_pc;
        put(s_op(2, 10, 32'h1f0));
        store_check(8, base + 4);
        put(u_op(OPC_AU, 9, 0));
        base = last_pc;
        put(i_op(OPC_JR, 0, 11, 9, 12));
        put(s_op(2, 10, 32'h1f0));
        store_check(11, base + 8);
        // x0 stays zero
        put(i_op(OPC_I, 0, 0, 0, 5));
        store_check(0, 32'h0);
        put(i_op(OPC_L, 2, 5, 0, 32'h100));
        put(i_op(OPC_I, 0, 5, 5, 1));
        store_check(5, 32'hcafe_f00e);
        alu_check(r_op(0, 0, 3, 1, 2), 32'h1234_5675);
        alu_check(r_op(32, 0, 3, 1, 2), 32'h1234_567b);
        alu_check(r_op(0, 2, 3, 2, 1), 32'h1);
        alu_check(r_op(0, 3, 3, 2, 1), 32'h0);
        alu_check(r_op(0, 4, 3, 1, 2), 32'hedcb_a985);
        alu_check(r_op(0, 6, 3, 1, 2), 32'hffff_fffd);
        alu_check(r_op(0, 7, 3, 1, 2), 32'h1234_5678);
        put(i_op(OPC_I, 0, 4, 0, 4));
        alu_check(r_op(0, 1, 3, 1, 4), 32'h2345_6780);
        alu_check(r_op(0, 5, 3, 2, 4), 32'h0fff_ffff);
        alu_check(r_op(32, 5, 3, 2, 4), 32'hffff_ffff);
        alu_check(i_op(OPC_I, 2, 3, 2, 0), 32'h1);
        alu_check(i_op(OPC_I, 3, 3, 2, 5), 32'h0);
        alu_check(i_op(OPC_I, 4, 3, 1, 32'hff), 32'h1234_5687);
        alu_check(i_op(OPC_I, 6, 3, 1, 32'h0f), 32'h1234_567f);
        alu_check(i_op(OPC_I, 7, 3, 1, 32'hf0), 32'h0000_0070);
        alu_check(i_op(OPC_I, 1, 3, 1, 8), 32'h3456_7800);
        alu_check(i_op(OPC_I, 5, 3, 1, 8), 32'h0012_3456);
        alu_check(i_op(OPC_I, 5, 3, 2, 32'h401), 32'hffff_fffe);
        put(u_op(OPC_AU, 3, 1));
        store_check(3, last_pc + 32'h1000);
        // last store marks the end
        put(s_op(1, 10, 32'h1fc));
        exp_addr.push_back(END_ADDR);
        exp_data.push_back(32'h1234_5678);
        put(j_op(0, 0));
    endtask

    task automatic check_write();
        assert (wb_sel == 4'hf)
            else abort_run($sformatf("Error wb_sel: got %01h, expected f", wb_sel));
        if (wb_adr >= 32'h200) begin
            assert (exp_idx < exp_addr.size())
                else abort_run($sformatf("store to %08h after the last expected store", wb_adr));
            assert (wb_adr == exp_addr[exp_idx])
                else abort_run($sformatf("Error wb_adr: got %08h, expected %08h",
                                         wb_adr, exp_addr[exp_idx]));
            assert (wb_dat_wr == exp_data[exp_idx])
                else abort_run($sformatf("Error wb_dat_wr: got %08h, expected %08h at %08h",
                                         wb_dat_wr, exp_data[exp_idx], wb_adr));
            exp_idx = exp_idx + 1;
            if (wb_adr == END_ADDR) begin
                test_done = 1'b1;
            end
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory slave, acks after 0 to 3 wait cycles
    initial begin : bus_slave
        logic in_cycle;
        int wait_left;
        wb_ack = 1'b0;
        wb_dat_rd = '0;
        in_cycle = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge clk);
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb && !reset) begin
                if (!in_cycle) begin
                    in_cycle = 1'b1;
                    wait_left = take_bits(2);
                end
                if (wait_left == 0) begin
                    in_cycle = 1'b0;
                    if (wb_we) begin
                        check_write();
                        mem[wb_adr[9:2]] = wb_dat_wr;
                    end else begin
                        wb_dat_rd = mem[wb_adr[9:2]];
                    end
                    wb_ack = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    initial begin : main
        int cycles;
        reset = 1'b1;
        lfsr = 32'hb9f;
        exp_idx = 0;
        test_done = 1'b0;
        load_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (!test_done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (test_done) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("no store to the end address within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

endmodule

// File: cpu.f
logic/cpu_pkg.sv
logic/mem_req_if.sv
logic/alu.sv
logic/decoder.sv
logic/registers.sv
logic/wb_master.sv
logic/control.sv
logic/cpu.sv
dv/cpu_asserts.sv
dv/tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= cpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
